/* design/comb_defs.svh */
// comb filter build constants
// sample and gain widths, echo delay, register map
`ifndef COMB_DEFS_SVH
`define COMB_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////////////////////

// signed audio sample
`define COMB_SAMPLE_W 16

// signed gain, Q1.7
`define COMB_GAIN_W 8
`define COMB_GAIN_FRAC 7

// echo delay in accepted samples
// longer than 32 so the delay line spans a long chain
`define COMB_DELAY 40

////////////////////////////////////////////////////////////////////////////
// wishbone register map, word addresses
////////////////////////////////////////////////////////////////////////////

`define COMB_WB_AW 4
`define COMB_ADDR_CTRL 0
`define COMB_ADDR_GAIN 1
`define COMB_ADDR_COUNT 2

`endif

/* design/comb_pkg.sv */
// comb filter shared types
// sample, gain, product and register address enum

`include "comb_defs.svh"

package comb_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // arithmetic types
  ////////////////////////////////////////////////////////////////////////////

  // one audio sample
  typedef logic signed [`COMB_SAMPLE_W-1:0] sample_t;

  // echo gain, divide by 2**COMB_GAIN_FRAC for the real value
  typedef logic signed [`COMB_GAIN_W-1:0] gain_t;

  // full precision sample times gain
  typedef logic signed [`COMB_SAMPLE_W+`COMB_GAIN_W-1:0] product_t;

  ////////////////////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////////////////////

  // word addresses on the wishbone port
  typedef enum logic [`COMB_WB_AW-1:0] {
    REG_CTRL  = `COMB_WB_AW'(`COMB_ADDR_CTRL),
    REG_GAIN  = `COMB_WB_AW'(`COMB_ADDR_GAIN),
    REG_COUNT = `COMB_WB_AW'(`COMB_ADDR_COUNT)
  } comb_reg_e;

endpackage

/* design/sample_stream_if.sv */
// valid/ready sample stream interface
// source and sink modports
`timescale 1ns/1ps

interface sample_stream_if import comb_pkg::*; ();

  // handshake, transfer when both high on a rising edge
  logic valid;
  logic ready;

  // payload, held by the source until the transfer
  sample_t sample;

  // marks the final sample of a block
  logic last;

  // producer side
  modport source (
    output valid,
    output sample,
    output last,
    input  ready
  );

  // consumer side
  modport sink (
    input  valid,
    input  sample,
    input  last,
    output ready
  );

endinterface

/* design/shift_reg.sv */
// enable gated delay line of inferred registers
// DEPTH 0 gives a single register stage
`timescale 1ns/1ps

module shift_reg #(
  // bits per stage
  parameter int WIDTH = 1,
  // extra stages beyond the first
  parameter int DEPTH = 7
) (
  input  logic             clk,
  input  logic             ena,
  input  logic [WIDTH-1:0] din,
  output logic [WIDTH-1:0] dout
);

  ////////////////////////////////////////////////////////////////////////////
  // register chain
  ////////////////////////////////////////////////////////////////////////////

  // stage 0 takes din, stage DEPTH drives dout
  logic [WIDTH-1:0] stage [DEPTH+1];

  // all stages advance together on ena
  always_ff @(posedge clk) begin
    if (ena) begin
      stage[0] <= din;
      for (int i = 1; i <= DEPTH; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  // registered output straight off the last stage
  assign dout = stage[DEPTH];

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // enable stays known once driven
  // an x here would smear unknowns down the whole chain
  a_ena_known : assert property (
    @(posedge clk) !$isunknown(ena) |=> !$isunknown(ena)
  ) else $error("shift_reg ena went unknown");

endmodule

/* design/comb_regs.sv */
// wishbone classic register slave for the comb filter
// ctrl (bypass), gain and read only output sample count
`timescale 1ns/1ps

`include "comb_defs.svh"

module comb_regs import comb_pkg::*; (
  input  logic                   clk,
  input  logic                   arst_n,

  // wishbone classic slave
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  logic [`COMB_WB_AW-1:0] wb_adr,
  input  logic [31:0]            wb_dat_w,
  output logic [31:0]            wb_dat_r,
  output logic                   wb_ack,

  // datapath control and status
  input  logic                   out_fire,
  output logic                   bypass,
  output gain_t                  gain
);

  ////////////////////////////////////////////////////////////////////////////
  // bus decode
  ////////////////////////////////////////////////////////////////////////////

  // new request with ack not yet given
  logic      req;
  comb_reg_e addr;
  logic      wr_en;
  logic [31:0] rd_data;

  // wrapping count of output transfers
  logic [31:0] count;

  assign req   = wb_cyc && wb_stb && !wb_ack;
  assign addr  = comb_reg_e'(wb_adr);
  assign wr_en = req && wb_we;

  // read mux with unmapped words reading zero
  always_comb begin
    rd_data = '0;
    case (addr)
      REG_CTRL:  rd_data = {31'd0, bypass};
      REG_GAIN:  rd_data = {{(32 - $bits(gain_t)){1'b0}}, gain};
      REG_COUNT: rd_data = count;
      default:   rd_data = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // ack and read data
  ////////////////////////////////////////////////////////////////////////////

  // single cycle ack one clock after the strobe is seen
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req;
    end
  end

  // read data lands with the ack
  always_ff @(posedge clk) begin
    if (req) begin
      wb_dat_r <= rd_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // control registers
  ////////////////////////////////////////////////////////////////////////////

  // writes land on the same edge that raises ack
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bypass <= 1'b0;
      gain   <= '0;
    end else if (wr_en) begin
      case (addr)
        REG_CTRL: bypass <= wb_dat_w[0];
        REG_GAIN: gain   <= gain_t'(wb_dat_w[$bits(gain_t)-1:0]);
        // count is read only and other words ignore writes
        default: ;
      endcase
    end
  end

  // output sample counter
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else if (out_fire) begin
      count <= count + 32'd1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // classic cycle gives a single ack pulse per access
  a_ack_pulse : assert property (
    @(posedge clk) disable iff (!arst_n)
    wb_ack |=> !wb_ack
  ) else $error("wb_ack held for more than one cycle");

endmodule

/* design/comb_datapath.sv */
// feed forward comb datapath
// delay line, fill mask, gain multiply, add, saturate, 2 stage output
`timescale 1ns/1ps

`include "comb_defs.svh"

module comb_datapath import comb_pkg::*; #(
  // echo delay in accepted samples
  parameter int DELAY = `COMB_DELAY
) (
  input  logic            clk,
  input  logic            arst_n,

  // control from the register slave
  input  logic            bypass,
  input  gain_t           gain,

  // streams
  sample_stream_if.sink   in,
  sample_stream_if.source out,

  // one pulse per output transfer
  output logic            out_fire
);

  localparam int FILL_W = $clog2(DELAY + 1);
  localparam int ALIGN_W = $bits(sample_t) + 1;

  // pipeline control
  logic advance;
  logic in_fire;

  // delayed sample and fill mask
  sample_t           delayed;
  sample_t           delayed_m;
  logic [FILL_W-1:0] fill_cnt;
  logic              filled;

  // stage 1
  logic     s1_valid;
  logic     s1_bypass;
  product_t s1_prod;
  sample_t  s1_cur;
  logic     s1_last;

  // stage 2 sum and saturation
  product_t shifted;
  product_t sum;
  sample_t  sat;

  // stage 2 registers feed the output directly
  logic    s2_valid;
  sample_t s2_sample;
  logic    s2_last;

  ////////////////////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////////////////////

  // whole pipe moves when the output slot is free or being drained
  assign advance  = !s2_valid || out.ready;
  assign in.ready = advance;
  assign in_fire  = in.valid && advance;
  assign out_fire = out.valid && out.ready;

  ////////////////////////////////////////////////////////////////////////////
  // delay line and fill mask
  ////////////////////////////////////////////////////////////////////////////

  // shifts on accepted samples only so the delay is counted in samples
  shift_reg #(
    .WIDTH ($bits(sample_t)),
    .DEPTH (DELAY - 1)
  ) u_delay_line (
    .clk  (clk),
    .ena  (in_fire),
    .din  (in.sample),
    .dout (delayed)
  );

  // saturating count of accepted samples
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fill_cnt <= '0;
    end else if (in_fire && !filled) begin
      fill_cnt <= fill_cnt + 1'b1;
    end
  end

  assign filled = (fill_cnt == FILL_W'(DELAY));

  // stale line contents count as silence
  assign delayed_m = filled ? delayed : '0;

  ////////////////////////////////////////////////////////////////////////////
  // stage 1 multiply
  ////////////////////////////////////////////////////////////////////////////

  // current sample and last ride alongside the product
  shift_reg #(
    .WIDTH (ALIGN_W),
    .DEPTH (0)
  ) u_align (
    .clk  (clk),
    .ena  (advance),
    .din  ({in.last, in.sample}),
    .dout ({s1_last, s1_cur})
  );

  // gain and bypass sampled as the sample enters
  always_ff @(posedge clk) begin
    if (advance) begin
      s1_prod   <= delayed_m * gain;
      s1_bypass <= bypass;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage 2 add and saturate
  ////////////////////////////////////////////////////////////////////////////

  // arithmetic shift rounds toward minus infinity
  assign shifted = s1_prod >>> `COMB_GAIN_FRAC;
  assign sum     = product_t'(s1_cur) + shifted;

  // clamp to the sample range
  always_comb begin
    if (sum > product_t'(16'sh7fff)) begin
      sat = 16'sh7fff;
    end else if (sum < product_t'(16'sh8000)) begin
      sat = 16'sh8000;
    end else begin
      sat = sample_t'(sum);
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      s2_sample <= s1_bypass ? s1_cur : sat;
      s2_last   <= s1_last;
    end
  end

  // valid bits
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else if (advance) begin
      s1_valid <= in.valid;
      s2_valid <= s1_valid;
    end
  end

  assign out.valid  = s2_valid;
  assign out.sample = s2_sample;
  assign out.last   = s2_last;

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // stalled output holds its word until taken
  a_out_hold : assert property (
    @(posedge clk) disable iff (!arst_n)
    out.valid && !out.ready |=> out.valid && $stable(out.sample) && $stable(out.last)
  ) else $error("output changed while stalled");

  // input accepts exactly when the output side can move
  a_in_ready : assert property (
    @(posedge clk) disable iff (!arst_n)
    in.ready == (!out.valid || out.ready)
  ) else $error("in_ready does not track output back-pressure");

endmodule

/* design/comb_top.sv */
// comb filter top level
// wishbone register slave plus streaming datapath, plain ports
`timescale 1ns/1ps

`include "comb_defs.svh"

module comb_top import comb_pkg::*; (
  input  logic                   clk,
  input  logic                   arst_n,

  // wishbone classic slave
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  logic [`COMB_WB_AW-1:0] wb_adr,
  input  logic [31:0]            wb_dat_w,
  output logic [31:0]            wb_dat_r,
  output logic                   wb_ack,

  // input stream
  input  logic                   in_valid,
  output logic                   in_ready,
  input  sample_t                in_sample,
  input  logic                   in_last,

  // output stream
  output logic                   out_valid,
  input  logic                   out_ready,
  output sample_t                out_sample,
  output logic                   out_last
);

  // control between slave and datapath
  logic  bypass;
  gain_t gain;
  logic  out_fire;

  // stream bundles
  sample_stream_if in_if ();
  sample_stream_if out_if ();

  // input side into the bundle
  assign in_if.valid  = in_valid;
  assign in_if.sample = in_sample;
  assign in_if.last   = in_last;
  assign in_ready     = in_if.ready;

  // output side out of the bundle
  assign out_valid    = out_if.valid;
  assign out_sample   = out_if.sample;
  assign out_last     = out_if.last;
  assign out_if.ready = out_ready;

  comb_regs u_regs (
    .clk      (clk),
    .arst_n   (arst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .out_fire (out_fire),
    .bypass   (bypass),
    .gain     (gain)
  );

  comb_datapath #(
    .DELAY (`COMB_DELAY)
  ) u_datapath (
    .clk      (clk),
    .arst_n   (arst_n),
    .bypass   (bypass),
    .gain     (gain),
    .in       (in_if.sink),
    .out      (out_if.source),
    .out_fire (out_fire)
  );

endmodule

/* tests/tb_comb.sv */
// testbench for the comb filter top level
// wishbone and stream stimulus, queue reference model, checking assertions
`timescale 1ns/1ps

`include "comb_defs.svh"

module tb_comb import comb_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 4000;
  localparam int DELAY = `COMB_DELAY;

  logic                   clk;
  logic                   arst_n;
  logic                   wb_cyc;
  logic                   wb_stb;
  logic                   wb_we;
  logic [`COMB_WB_AW-1:0] wb_adr;
  logic [31:0]            wb_dat_w;
  logic [31:0]            wb_dat_r;
  logic                   wb_ack;
  logic                   in_valid;
  logic                   in_ready;
  sample_t                in_sample;
  logic                   in_last;
  logic                   out_valid;
  logic                   out_ready;
  sample_t                out_sample;
  logic                   out_last;

  integer seed;
  int     errors;
  int     err_mark;
  int     tests;
  int     cycles;
  int     out_cnt;
  logic   stall_en;

  // model state changes only while the pipe is empty
  logic model_bypass;
  int   model_gain;

  // every accepted sample and the expected {last, sample} still in flight
  sample_t     hist[$];
  logic [16:0] exp_q[$];
  logic [16:0] exp_head;
  logic        exp_any;

  comb_top u_dut (
    .clk (clk), .arst_n (arst_n),
    .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
    .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
    .in_valid (in_valid), .in_ready (in_ready), .in_sample (in_sample), .in_last (in_last),
    .out_valid (out_valid), .out_ready (out_ready), .out_sample (out_sample),
    .out_last (out_last)
  );

  always #2 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic sample_t clamp16(input int v);
    if (v > 32767) return 16'sh7fff;
    if (v < -32768) return -16'sh8000;
    return sample_t'(v);
  endfunction

  // x[n] + floor(g * x[n-DELAY] / 128) with the older term zero until the line fills
  function automatic sample_t echo_expected(input sample_t cur);
    int old;
    int prod;
    old = 0;
    if (model_bypass) return cur;
    if (hist.size() >= DELAY) old = hist[hist.size() - DELAY];
    prod = old * model_gain;
    return clamp16(int'(cur) + (prod >>> `COMB_GAIN_FRAC));
  endfunction

  // pop on output transfers and push on input transfers
  always @(posedge clk) begin
    if (arst_n) begin
      if (out_valid && out_ready && exp_q.size() > 0) begin
        void'(exp_q.pop_front());
      end
      if (out_valid && out_ready) out_cnt++;
      if (in_valid && in_ready) begin
        exp_q.push_back({in_last, echo_expected(in_sample)});
        hist.push_back(in_sample);
      end
      exp_any  <= (exp_q.size() > 0);
      exp_head <= (exp_q.size() > 0) ? exp_q[0] : '0;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the stream never drained", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  a_out_match : assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && out_ready |-> exp_any && {out_last, out_sample} == exp_head
  ) else begin
    errors++;
    if (!$sampled(exp_any))
      $display("output transfer with no input sample outstanding");
    else if ($sampled(out_sample) != $sampled(exp_head[15:0]))
      $display("Mismatch out_sample exp %h got %h",
               $sampled(exp_head[15:0]), $sampled(out_sample));
    else
      $display("Mismatch out_last exp %h got %h", $sampled(exp_head[16]), $sampled(out_last));
  end

  a_out_hold : assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_sample) && $stable(out_last)
  ) else begin
    errors++;
    $display("output dropped or changed while stalled");
  end

  a_ack_next : assert property (@(posedge clk) disable iff (!arst_n)
    wb_cyc && wb_stb && !wb_ack |=> wb_ack
  ) else begin
    errors++;
    $display("no wb_ack one cycle after the strobe");
  end

  a_ack_once : assert property (@(posedge clk) disable iff (!arst_n)
    wb_ack |=> !wb_ack
  ) else begin
    errors++;
    $display("wb_ack high for two cycles in a row");
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  // one clock with a fresh out_ready when stalls are on
  task automatic tick();
    logic [31:0] rnd;
    @(posedge clk);
    rnd = $random(seed);
    out_ready <= stall_en ? (rnd[1:0] != 2'b00) : 1'b1;
  endtask

  task automatic wb_xfer(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                         output logic [31:0] rdat);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdat;
    do @(posedge clk); while (!wb_ack);
    rdat = wb_dat_r;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_write(input logic [3:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    wb_xfer(1'b1, adr, data, unused);
  endtask

  task automatic wb_check(input logic [3:0] adr, input logic [31:0] exp, input string name);
    logic [31:0] got;
    wb_xfer(1'b0, adr, 32'd0, got);
    assert (got == exp) else begin
      errors++;
      $display("Mismatch wb_dat_r at %s exp %h got %h", name, exp, got);
    end
  endtask

  // pipe is empty here so the model can switch with the registers
  task automatic set_mode(input logic byp, input logic [7:0] g);
    wb_write(REG_CTRL, {31'd0, byp});
    wb_write(REG_GAIN, {24'd0, g});
    model_bypass = byp;
    model_gain   = gain_t'(g);
  endtask

  task automatic push_sample(input sample_t v, input logic last);
    in_valid  <= 1'b1;
    in_sample <= v;
    in_last   <= last;
    do tick(); while (!in_ready);
  endtask

  // kind 0 is random full range and kind 1 large with sign from index parity
  task automatic send_block(input int n, input int kind);
    logic [31:0] rnd;
    sample_t     mag;
    for (int i = 0; i < n; i++) begin
      rnd = $random(seed);
      mag = 16'sh6000 + sample_t'(rnd[11:0]);
      push_sample(kind == 0 ? sample_t'(rnd[15:0]) : (i[0] ? -mag : mag), rnd[20]);
    end
    in_valid <= 1'b0;
    while (exp_any) tick();
    tick();
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s: %s", tests, name, errors == err_mark ? "ok" : "FAILED");
    err_mark = errors;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    arst_n = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    in_valid = 1'b0;
    in_sample = '0;
    in_last = 1'b0;
    out_ready = 1'b1;
    seed = 32'h7a32_2ccf;
    errors = 0;
    err_mark = 0;
    tests = 0;
    cycles = 0;
    out_cnt = 0;
    stall_en = 1'b0;
    model_bypass = 1'b0;
    model_gain = 0;
    exp_any = 1'b0;
    exp_head = '0;
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    tick();
    assert (!out_valid && !wb_ack) else begin
      errors++;
      $display("outputs not idle after reset");
    end

    wb_check(REG_CTRL, 32'd0, "CTRL");
    wb_check(REG_GAIN, 32'd0, "GAIN");
    wb_write(REG_CTRL, 32'd1);
    wb_check(REG_CTRL, 32'd1, "CTRL");
    wb_write(REG_GAIN, 32'h0000_00a5);
    wb_check(REG_GAIN, 32'h0000_00a5, "GAIN");
    wb_write(REG_COUNT, 32'h1234_5678);
    wb_check(REG_COUNT, 32'd0, "COUNT");
    end_test("register access");

    // 0.5 echo where the first DELAY samples after reset see a masked delay term
    set_mode(1'b0, 8'd64);
    send_block(100, 0);
    end_test("echo with fill mask");

    set_mode(1'b1, 8'd0);
    send_block(30, 0);
    end_test("bypass");

    set_mode(1'b0, 8'd127);
    send_block(90, 1);
    end_test("saturation");

    stall_en = 1'b1;
    set_mode(1'b0, 8'hb3);
    send_block(120, 0);
    stall_en = 1'b0;
    tick();
    end_test("back-pressure");

    wb_check(REG_COUNT, out_cnt, "COUNT");
    end_test("sample counter");

    $display("%0d tests, %0d outputs checked, %0d errors", tests, out_cnt, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+design
design/comb_pkg.sv
design/sample_stream_if.sv
design/shift_reg.sv
design/comb_regs.sv
design/comb_datapath.sv
design/comb_top.sv
tests/tb_comb.sv
